/* design/socket_cmd_queue.sv */
`timescale 1ns/1ps

module socket_cmd_queue import socket_pkg::*; #(
	parameter int CREDITS = 4,
	parameter int SOCKID_BITS = 7,
	localparam int PTR_BITS = (CREDITS > 1) ? $clog2(CREDITS) : 1,
	localparam int CNT_BITS = $clog2(CREDITS + 1)
) (
	input  logic                   clk,
	input  logic                   reset,
	input  logic                   cmd_valid,
	input  sock_op_t               cmd_op,
	input  ip_addr_t               cmd_addr,
	input  tcp_port_t              cmd_client_port,
	input  tcp_port_t              cmd_server_port,
	input  logic [SOCKID_BITS-1:0] cmd_sockid,
	output logic                   q_valid,
	output sock_op_t               q_op,
	output ip_addr_t               q_addr,
	output tcp_port_t              q_client_port,
	output tcp_port_t              q_server_port,
	output logic [SOCKID_BITS-1:0] q_sockid,
	input  logic                   q_pop,
	output logic                   credit_return
);

	// One storage array per command field
	sock_op_t               op_mem     [CREDITS];
	ip_addr_t               addr_mem   [CREDITS];
	tcp_port_t              cport_mem  [CREDITS];
	tcp_port_t              sport_mem  [CREDITS];
	logic [SOCKID_BITS-1:0] sockid_mem [CREDITS];

	logic [PTR_BITS-1:0] wr_ptr;
	logic [PTR_BITS-1:0] rd_ptr;
	logic [CNT_BITS-1:0] count;

	////////////////////////////////////////////////////////////////////////////
	// Storage

	// Sender holds a credit for every push, so a push never finds the FIFO full
	always_ff @(posedge clk) begin
		if (cmd_valid) begin
			op_mem[wr_ptr]     <= cmd_op;
			addr_mem[wr_ptr]   <= cmd_addr;
			cport_mem[wr_ptr]  <= cmd_client_port;
			sport_mem[wr_ptr]  <= cmd_server_port;
			sockid_mem[wr_ptr] <= cmd_sockid;
		end
	end

	// Head entry, valid one cycle after the push
	assign q_valid       = (count != '0);
	assign q_op          = op_mem[rd_ptr];
	assign q_addr        = addr_mem[rd_ptr];
	assign q_client_port = cport_mem[rd_ptr];
	assign q_server_port = sport_mem[rd_ptr];
	assign q_sockid      = sockid_mem[rd_ptr];

	////////////////////////////////////////////////////////////////////////////
	// Pointers, fill count and credits

	always_ff @(posedge clk) begin
		if (reset) begin
			wr_ptr        <= '0;
			rd_ptr        <= '0;
			count         <= '0;
			credit_return <= 1'b0;
		end else begin
			if (cmd_valid) begin
				wr_ptr <= (wr_ptr == PTR_BITS'(CREDITS - 1)) ? '0 : wr_ptr + 1'b1;
			end
			if (q_pop) begin
				rd_ptr <= (rd_ptr == PTR_BITS'(CREDITS - 1)) ? '0 : rd_ptr + 1'b1;
			end
			case ({cmd_valid, q_pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
			// One credit back per popped entry, a cycle after the pop
			credit_return <= q_pop;
		end
	end

	// A full FIFO means the sender pushed with no credit left
	a_no_push_full: assert property (@(posedge clk) disable iff (reset)
		cmd_valid |-> (count != CNT_BITS'(CREDITS)));

	a_no_pop_empty: assert property (@(posedge clk) disable iff (reset)
		q_pop |-> (count != '0));

endmodule

/* design/socket_pkg.sv */
package socket_pkg;

	////////////////////////////////////////////////////////////////////////////
	// Header field types

	// Remote IPv4 address of the connection
	typedef logic [31:0] ip_addr_t;

	// TCP port, used for both the client and the server side
	typedef logic [15:0] tcp_port_t;

	// Raw tuple hash before it is cut down to a bin index
	typedef logic [15:0] sock_hash_t;

	// Upper bound on socket ID width, checked by the table at elaboration
	localparam int SOCKID_MAX_BITS = 16;

	////////////////////////////////////////////////////////////////////////////
	// Command and state encodings

	// Command kinds coming from the packet parser
	typedef enum logic [1:0] {
		op_lookup = 2'd0,
		op_insert = 2'd1,
		op_remove = 2'd2
	} sock_op_t;

	// Table FSM
	// read_wait covers the memory read pipeline before the first compare
	typedef enum logic [2:0] {
		st_idle         = 3'd0,
		st_read_wait    = 3'd1,
		st_lookup_cmp   = 3'd2,
		st_insert_cmp   = 3'd3,
		st_write_settle = 3'd4
	} table_state_t;

endpackage

/* design/socket_subsystem.sv */
`timescale 1ns/1ps

module socket_subsystem import socket_pkg::*; #(
	parameter int WAYS = 4,
	parameter int LATENCY = 2,
	parameter int BINS = 16,
	parameter int CREDITS = 4,
	localparam int SOCKID_BITS = $clog2(WAYS * LATENCY * BINS)
) (
	input  logic                   clk,
	input  logic                   reset,
	input  logic                   cmd_valid,
	input  sock_op_t               cmd_op,
	input  ip_addr_t               cmd_addr,
	input  tcp_port_t              cmd_client_port,
	input  tcp_port_t              cmd_server_port,
	input  logic [SOCKID_BITS-1:0] cmd_sockid,
	output logic                   credit_return,
	output logic                   result_valid,
	output sock_op_t               result_op,
	output logic                   result_hit,
	output logic                   result_fail,
	output logic [SOCKID_BITS-1:0] result_sockid
);

	// Queue head towards the table
	logic                   q_valid;
	sock_op_t               q_op;
	ip_addr_t               q_addr;
	tcp_port_t              q_client_port;
	tcp_port_t              q_server_port;
	logic [SOCKID_BITS-1:0] q_sockid;
	logic                   q_pop;

	socket_cmd_queue #(
		.CREDITS     (CREDITS),
		.SOCKID_BITS (SOCKID_BITS)
	) i_cmd_queue (
		.clk, .reset, .cmd_valid, .cmd_op, .cmd_addr, .cmd_client_port,
		.cmd_server_port, .cmd_sockid, .q_valid, .q_op, .q_addr, .q_client_port,
		.q_server_port, .q_sockid, .q_pop, .credit_return
	);

	socket_table #(
		.WAYS    (WAYS),
		.LATENCY (LATENCY),
		.BINS    (BINS)
	) i_table (
		.clk, .reset, .q_valid, .q_op, .q_addr, .q_client_port, .q_server_port,
		.q_sockid, .q_pop, .result_valid, .result_op, .result_hit, .result_fail,
		.result_sockid
	);

endmodule

/* design/socket_table.sv */
`timescale 1ns/1ps

module socket_table import socket_pkg::*; #(
	parameter int WAYS = 4,
	parameter int LATENCY = 2,
	parameter int BINS = 16,
	localparam int COL_BITS = $clog2(WAYS),
	localparam int LAT_BITS = $clog2(LATENCY),
	localparam int WAY_SIZE = LATENCY * BINS,
	localparam int WAY_BITS = $clog2(WAY_SIZE),
	localparam int SOCKID_BITS = WAY_BITS + COL_BITS
) (
	input  logic                   clk,
	input  logic                   reset,
	input  logic                   q_valid,
	input  sock_op_t               q_op,
	input  ip_addr_t               q_addr,
	input  tcp_port_t              q_client_port,
	input  tcp_port_t              q_server_port,
	input  logic [SOCKID_BITS-1:0] q_sockid,
	output logic                   q_pop,
	output logic                   result_valid,
	output sock_op_t               result_op,
	output logic                   result_hit,
	output logic                   result_fail,
	output logic [SOCKID_BITS-1:0] result_sockid
);

	// Entry is {valid, address, client port, server port}
	localparam int TUPLE_BITS = $bits(ip_addr_t) + 2 * $bits(tcp_port_t);
	localparam int ENTRY_BITS = TUPLE_BITS + 1;

	if (SOCKID_BITS > SOCKID_MAX_BITS) begin : g_sockid_check
		$error("socket ID width exceeds SOCKID_MAX_BITS");
	end

	table_state_t state;

	// Command held for the whole search
	sock_op_t               cmd_op;
	ip_addr_t               cmd_addr;
	tcp_port_t              cmd_client_port;
	tcp_port_t              cmd_server_port;
	logic [TUPLE_BITS-1:0]  cmd_tuple;
	sock_hash_t             q_hash;

	// Memory ports, shared by all ways except the write enables
	logic [WAYS-1:0]       wr_en;
	logic [WAY_BITS-1:0]   wr_addr;
	logic [ENTRY_BITS-1:0] wr_data;
	logic                  rd_en;
	logic [WAY_BITS-1:0]   rd_addr;
	logic [WAY_BITS-1:0]   rd_row;
	logic [ENTRY_BITS-1:0] rd_entry [WAYS];

	logic                match_found;
	logic [COL_BITS-1:0] match_way;
	logic                free_found;
	logic [COL_BITS-1:0] free_way;
	logic                last_row;

	////////////////////////////////////////////////////////////////////////////
	// Cache ways, all read in parallel

	for (genvar w = 0; w < WAYS; w++) begin : g_way
		socket_way_ram #(
			.WIDTH (ENTRY_BITS),
			.DEPTH (WAY_SIZE)
		) i_way_ram (
			.clk     (clk),
			.wr_en   (wr_en[w]),
			.wr_addr (wr_addr),
			.wr_data (wr_data),
			.rd_en   (rd_en),
			.rd_addr (rd_addr),
			.rd_data (rd_entry[w])
		);
	end

	////////////////////////////////////////////////////////////////////////////
	// Hash and compare

	// XOR fold of the tuple into 16 bits
	assign q_hash = q_client_port ^ q_server_port ^ q_addr[31:16] ^ q_addr[15:0];
	assign cmd_tuple = {cmd_addr, cmd_client_port, cmd_server_port};

	// Walk downward so the lowest matching or free way wins
	always_comb begin
		match_found = 1'b0;
		match_way   = '0;
		free_found  = 1'b0;
		free_way    = '0;
		for (int i = WAYS - 1; i >= 0; i--) begin
			if (rd_entry[i][ENTRY_BITS-1] && (rd_entry[i][TUPLE_BITS-1:0] == cmd_tuple)) begin
				match_found = 1'b1;
				match_way   = COL_BITS'(i);
			end
			if (!rd_entry[i][ENTRY_BITS-1]) begin
				free_found = 1'b1;
				free_way   = COL_BITS'(i);
			end
		end
	end

	// Bins start on a LATENCY boundary, so all ones marks the final row
	assign last_row = (rd_row[LAT_BITS-1:0] == {LAT_BITS{1'b1}});

	assign q_pop = (state == st_idle) && q_valid;
	assign rd_en = (state == st_read_wait) || (state == st_lookup_cmp) ||
		(state == st_insert_cmp);

	////////////////////////////////////////////////////////////////////////////
	// Main FSM

	always_ff @(posedge clk) begin
		// rd_data lags rd_addr by one edge, rd_row tracks which row it holds
		rd_row       <= rd_addr;
		wr_en        <= '0;
		result_valid <= 1'b0;
		case (state)
			st_idle: begin
				if (q_pop) begin
					cmd_op          <= q_op;
					cmd_addr        <= q_addr;
					cmd_client_port <= q_client_port;
					cmd_server_port <= q_server_port;
					result_op       <= q_op;
					result_hit      <= 1'b0;
					result_fail     <= 1'b0;
					if (q_op == op_remove) begin
						// Clear the named slot and answer at once
						wr_en[q_sockid[COL_BITS-1:0]] <= 1'b1;
						wr_addr       <= q_sockid[SOCKID_BITS-1:COL_BITS];
						wr_data       <= '0;
						result_valid  <= 1'b1;
						result_sockid <= q_sockid;
						state         <= st_write_settle;
					end else begin
						rd_addr <= {q_hash[WAY_BITS-1:LAT_BITS], {LAT_BITS{1'b0}}};
						state   <= st_read_wait;
					end
				end
			end
			// First row still in the memory pipeline
			st_read_wait: begin
				rd_addr <= rd_addr + 1'b1;
				state   <= (cmd_op == op_insert) ? st_insert_cmp : st_lookup_cmp;
			end
			st_lookup_cmp: begin
				rd_addr <= rd_addr + 1'b1;
				if (match_found || last_row) begin
					result_valid  <= 1'b1;
					result_hit    <= match_found;
					result_sockid <= {rd_row, match_way};
					// Settle too, so a queued remove cannot answer in the next cycle
					state         <= st_write_settle;
				end
			end
			st_insert_cmp: begin
				rd_addr <= rd_addr + 1'b1;
				if (free_found) begin
					wr_en[free_way] <= 1'b1;
					wr_addr         <= rd_row;
					wr_data         <= {1'b1, cmd_tuple};
					result_valid    <= 1'b1;
					result_sockid   <= {rd_row, free_way};
					state           <= st_write_settle;
				end else if (last_row) begin
					// Bin full
					result_valid <= 1'b1;
					result_fail  <= 1'b1;
					state        <= st_write_settle;
				end
			end
			// Write and result pulse end here, next read sees the write
			st_write_settle: state <= st_idle;
			default:         state <= st_idle;
		endcase
		if (reset) begin
			state        <= st_idle;
			wr_en        <= '0;
			result_valid <= 1'b0;
		end
	end

	// A write lands only together with the result of its command
	a_wr_onehot: assert property (@(posedge clk) disable iff (reset)
		(wr_en != '0) |-> $onehot(wr_en) && result_valid);

	a_result_pulse: assert property (@(posedge clk) disable iff (reset)
		result_valid |=> !result_valid);

	// A pop waits until the previous answer and its write are done
	a_pop_from_idle: assert property (@(posedge clk) disable iff (reset)
		q_pop |-> !result_valid && (wr_en == '0));

endmodule

/* design/socket_way_ram.sv */
`timescale 1ns/1ps

module socket_way_ram #(
	parameter int WIDTH = 65,
	parameter int DEPTH = 32,
	localparam int ADDR_BITS = $clog2(DEPTH)
) (
	input  logic                 clk,
	input  logic                 wr_en,
	input  logic [ADDR_BITS-1:0] wr_addr,
	input  logic [WIDTH-1:0]     wr_data,
	input  logic                 rd_en,
	input  logic [ADDR_BITS-1:0] rd_addr,
	output logic [WIDTH-1:0]     rd_data
);

	logic [WIDTH-1:0] mem [DEPTH];

	// All zero means every slot starts with its valid bit clear
	initial begin
		for (int i = 0; i < DEPTH; i++) begin
			mem[i] = '0;
		end
	end

	// Write port
	always_ff @(posedge clk) begin
		if (wr_en) begin
			mem[wr_addr] <= wr_data;
		end
	end

	// Registered read port, holds its last value while rd_en is low
	always_ff @(posedge clk) begin
		if (rd_en) begin
			rd_data <= mem[rd_addr];
		end
	end

endmodule

/* list.f */
design/socket_pkg.sv
design/socket_way_ram.sv
design/socket_cmd_queue.sv
design/socket_table.sv
design/socket_subsystem.sv
testbench/socket_checker.sv
testbench/tb_socket.sv

/* run.sh */
#!/bin/sh
# Build and run the socket table testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_socket -f list.f -o sim_socket
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

./obj_dir/sim_socket > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "TEST FAILED" sim.log; then
	exit 1
fi
exit 0

/* testbench/socket_checker.sv */
`timescale 1ns/1ps

module socket_checker import socket_pkg::*; #(
	parameter int CREDITS = 4,
	parameter int SOCKID_BITS = 7
) (
	input  logic                   clk,
	input  logic                   reset,
	input  logic                   cmd_valid,
	input  logic                   credit_return,
	input  logic                   result_valid,
	input  sock_op_t               result_op,
	input  logic                   result_hit,
	input  logic                   result_fail,
	input  logic [SOCKID_BITS-1:0] result_sockid,
	input  logic                   exp_push,
	input  int                     exp_test,
	input  sock_op_t               exp_op,
	input  logic                   exp_hit,
	input  logic                   exp_fail,
	input  logic [SOCKID_BITS-1:0] exp_sockid,
	input  logic                   done,
	output int                     error_count,
	output int                     result_count
);

	// Expected results, oldest first
	int                     q_test [$];
	sock_op_t               q_op [$];
	logic                   q_hit [$];
	logic                   q_fail [$];
	logic [SOCKID_BITS-1:0] q_sockid [$];

	int credits_held;
	logic done_seen;

	initial begin
		error_count  = 0;
		result_count = 0;
		credits_held = CREDITS;
		done_seen    = 1'b0;
	end

	always @(posedge clk) begin
		int t;
		int bad;
		sock_op_t eop;
		logic ehit;
		logic efail;
		logic [SOCKID_BITS-1:0] esid;
		if (reset) begin
			credits_held = CREDITS;
		end else begin
			if (exp_push) begin
				q_test.push_back(exp_test);
				q_op.push_back(exp_op);
				q_hit.push_back(exp_hit);
				q_fail.push_back(exp_fail);
				q_sockid.push_back(exp_sockid);
			end
			// Sender side credit balance
			credits_held = credits_held - int'(cmd_valid) + int'(credit_return);
			// Outstanding credits never drop below zero
			if (credits_held > CREDITS) begin
				$display("credit returned that was never spent");
				error_count++;
			end
			if (result_valid) begin
				result_count++;
				if (q_test.size() == 0) begin
					$display("result arrived with no command pending");
					error_count++;
				end else begin
					t     = q_test.pop_front();
					eop   = q_op.pop_front();
					ehit  = q_hit.pop_front();
					efail = q_fail.pop_front();
					esid  = q_sockid.pop_front();
					bad   = 0;
					if (result_op != eop) begin
						$display("ERR result_op exp 0x%h got 0x%h (test %0d)", eop, result_op, t);
						bad++;
					end
					// Hit only means something for a lookup
					if (eop == op_lookup && result_hit != ehit) begin
						$display("ERR result_hit exp 0x%h got 0x%h (test %0d)", ehit, result_hit, t);
						bad++;
					end
					// Fail only means something for an insert
					if (eop == op_insert && result_fail != efail) begin
						$display("ERR result_fail exp 0x%h got 0x%h (test %0d)", efail, result_fail, t);
						bad++;
					end
					// No ID on a miss or a failed insert
					if (!((eop == op_lookup && !ehit) || (eop == op_insert && efail)) &&
						result_sockid != esid) begin
						$display("ERR result_sockid exp 0x%h got 0x%h (test %0d)", esid,
							result_sockid, t);
						bad++;
					end
					if (bad == 0) begin
						$display("test %0d PASS", t);
					end
					error_count += bad;
				end
			end
			// End of run checks and totals
			if (done && !done_seen) begin
				done_seen = 1'b1;
				if (credits_held != CREDITS) begin
					$display("credits not all returned, %0d of %0d held", credits_held, CREDITS);
					error_count++;
				end
				if (q_test.size() != 0) begin
					$display("%0d expected results never arrived", q_test.size());
					error_count++;
				end
				$display("results %0d, errors %0d", result_count, error_count);
			end
		end
	end

endmodule

/* testbench/socket_stim.txt */
# test op addr cport sport sockid exp_hit exp_fail exp_sockid flag
# op 0 lookup 1 insert 2 remove, flag 0 none 1 random gap 2 drain first 3 burst member
1 1 0a0a0000 0a5c 0050 00 0 0 18 0
2 1 0a0a0000 0b5c 0050 00 0 0 19 1
3 0 0a0a0000 0a5c 0050 00 1 0 18 0
4 0 0a0a0000 085c 0050 00 0 0 00 1
5 2 0a0a0000 0000 0000 18 0 0 18 0
6 0 0a0a0000 0a5c 0050 00 0 0 00 0
7 1 0a0a0000 095c 0050 00 0 0 18 1
8 1 0a0a0000 0a50 0050 00 0 0 28 0
9 1 0a0a0000 0b50 0050 00 0 0 29 0
10 1 0a0a0000 0850 0050 00 0 0 2a 1
11 1 0a0a0000 0950 0050 00 0 0 2b 0
12 1 0a0a0000 0e50 0050 00 0 0 2c 0
13 1 0a0a0000 0f50 0050 00 0 0 2d 1
14 1 0a0a0000 0c50 0050 00 0 0 2e 0
15 1 0a0a0000 0d50 0050 00 0 0 2f 0
16 1 0a0a0000 0250 0050 00 0 1 00 1
17 1 0a0a0000 0a48 0050 00 0 0 48 0
18 0 0a0a0000 0b50 0050 00 1 0 29 2
19 0 0a0a0000 0d50 0050 00 1 0 2f 3
20 0 0a0a0000 0b5c 0050 00 1 0 19 3
21 2 0a0a0000 0000 0000 2e 0 0 2e 3

/* testbench/tb_socket.sv */
`timescale 1ns/1ps

module tb_socket import socket_pkg::*; ();

	localparam int WAYS = 4;
	localparam int LATENCY = 2;
	localparam int BINS = 16;
	localparam int CREDITS = 4;
	localparam int SOCKID_BITS = $clog2(WAYS * LATENCY * BINS);
	localparam int MAX_CMDS = 64;

	logic                   clk;
	logic                   reset;
	logic                   cmd_valid;
	sock_op_t               cmd_op;
	ip_addr_t               cmd_addr;
	tcp_port_t              cmd_client_port;
	tcp_port_t              cmd_server_port;
	logic [SOCKID_BITS-1:0] cmd_sockid;
	logic                   credit_return;
	logic                   result_valid;
	sock_op_t               result_op;
	logic                   result_hit;
	logic                   result_fail;
	logic [SOCKID_BITS-1:0] result_sockid;

	// Expected values handed to the checker with each command
	logic                   exp_push;
	int                     exp_test;
	sock_op_t               exp_op;
	logic                   exp_hit;
	logic                   exp_fail;
	logic [SOCKID_BITS-1:0] exp_sockid;
	logic                   done;
	int                     checker_errors;
	int                     result_count;

	// Stimulus table loaded from the stim file
	int        st_test [MAX_CMDS];
	int        st_op [MAX_CMDS];
	logic [31:0] st_addr [MAX_CMDS];
	logic [31:0] st_cport [MAX_CMDS];
	logic [31:0] st_sport [MAX_CMDS];
	logic [31:0] st_sockid [MAX_CMDS];
	int        st_hit [MAX_CMDS];
	int        st_fail [MAX_CMDS];
	logic [31:0] st_exp_sockid [MAX_CMDS];
	int        st_flag [MAX_CMDS];

	int n_cmds;
	int credits;
	int driver_errors;
	int cycle_count;
	int timeout_limit;

	////////////////////////////////////////////////////////////////////////////
	// Clock, DUT and checker

	always #20 clk = ~clk;

	socket_subsystem #(
		.WAYS    (WAYS),
		.LATENCY (LATENCY),
		.BINS    (BINS),
		.CREDITS (CREDITS)
	) i_socket_subsystem (
		.clk, .reset, .cmd_valid, .cmd_op, .cmd_addr, .cmd_client_port, .cmd_server_port,
		.cmd_sockid, .credit_return, .result_valid, .result_op, .result_hit, .result_fail,
		.result_sockid
	);

	socket_checker #(
		.CREDITS     (CREDITS),
		.SOCKID_BITS (SOCKID_BITS)
	) i_checker (
		.clk, .reset, .cmd_valid, .credit_return, .result_valid, .result_op, .result_hit,
		.result_fail, .result_sockid, .exp_push, .exp_test, .exp_op, .exp_hit, .exp_fail,
		.exp_sockid, .done, .error_count (checker_errors), .result_count
	);

	// Sender credit counter
	always @(posedge clk) begin
		if (reset) begin
			credits <= CREDITS;
		end else begin
			credits <= credits - int'(cmd_valid) + int'(credit_return);
		end
	end

	// Run limit from the number of commands
	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (timeout_limit > 0 && cycle_count >= timeout_limit) begin
			$display("timeout: results missing");
			$display("TEST FAILED");
			$finish;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Driver

	// Credits after the current edge, valid right after a rising edge
	function automatic int credits_after_edge();
		return credits - int'(cmd_valid) + int'(credit_return);
	endfunction

	task automatic idle_cycle();
		@(posedge clk);
		cmd_valid <= 1'b0;
		exp_push  <= 1'b0;
	endtask

	task automatic load_stimulus();
		int fd;
		int n;
		string line;
		fd = $fopen("testbench/socket_stim.txt", "r");
		if (fd == 0) begin
			$display("cannot open stimulus file");
		end else begin
			while (!$feof(fd) && n_cmds < MAX_CMDS) begin
				line = "";
				void'($fgets(line, fd));
				// Comment lines start with a hash
				if (line.len() > 0 && line[0] != "#") begin
					n = $sscanf(line, "%d %d %h %h %h %h %d %d %h %d", st_test[n_cmds],
						st_op[n_cmds], st_addr[n_cmds], st_cport[n_cmds], st_sport[n_cmds],
						st_sockid[n_cmds], st_hit[n_cmds], st_fail[n_cmds],
						st_exp_sockid[n_cmds], st_flag[n_cmds]);
					if (n == 10) begin
						n_cmds++;
					end
				end
			end
			$fclose(fd);
		end
	endtask

	task automatic send_command(input int i);
		logic sent;
		sent = 1'b0;
		// Random idle gap
		if (st_flag[i] == 1) begin
			repeat ($urandom_range(4, 1)) idle_cycle();
		end
		// Wait for all earlier results, every credit must be back for the burst
		if (st_flag[i] == 2) begin
			while (result_count < i) begin
				idle_cycle();
			end
		end
		while (!sent) begin
			@(posedge clk);
			if (credits_after_edge() > 0) begin
				cmd_valid       <= 1'b1;
				cmd_op          <= sock_op_t'(st_op[i][1:0]);
				cmd_addr        <= st_addr[i];
				cmd_client_port <= st_cport[i][15:0];
				cmd_server_port <= st_sport[i][15:0];
				cmd_sockid      <= st_sockid[i][SOCKID_BITS-1:0];
				exp_push        <= 1'b1;
				exp_test        <= st_test[i];
				exp_op          <= sock_op_t'(st_op[i][1:0]);
				exp_hit         <= (st_hit[i] != 0);
				exp_fail        <= (st_fail[i] != 0);
				exp_sockid      <= st_exp_sockid[i][SOCKID_BITS-1:0];
				sent = 1'b1;
			end else begin
				cmd_valid <= 1'b0;
				exp_push  <= 1'b0;
				if (st_flag[i] == 3) begin
					$display("burst command of test %0d stalled for a credit", st_test[i]);
					driver_errors++;
				end
			end
		end
	endtask

	initial begin
		clk             = 1'b0;
		reset           = 1'b1;
		cmd_valid       = 1'b0;
		cmd_op          = op_lookup;
		cmd_addr        = '0;
		cmd_client_port = '0;
		cmd_server_port = '0;
		cmd_sockid      = '0;
		exp_push        = 1'b0;
		exp_test        = 0;
		exp_op          = op_lookup;
		exp_hit         = 1'b0;
		exp_fail        = 1'b0;
		exp_sockid      = '0;
		done            = 1'b0;
		n_cmds          = 0;
		credits         = CREDITS;
		driver_errors   = 0;
		cycle_count     = 0;
		timeout_limit   = 0;
		void'($urandom(3804));
		load_stimulus();
		if (n_cmds == 0) begin
			$display("no commands loaded from the stimulus file");
			$display("TEST FAILED");
			$finish;
		end else begin
			timeout_limit = n_cmds * (LATENCY + 8) + 200;
			repeat (4) @(posedge clk);
			reset <= 1'b0;
			for (int i = 0; i < n_cmds; i++) begin
				send_command(i);
			end
			idle_cycle();
			while (result_count < n_cmds) begin
				idle_cycle();
			end
			// Last credit comes back a cycle after the last pop
			repeat (3) idle_cycle();
			done <= 1'b1;
			repeat (2) @(posedge clk);
			if (driver_errors == 0 && checker_errors == 0) begin
				$display("TEST OK");
			end else begin
				$display("TEST FAILED");
			end
			$finish;
		end
	end

endmodule
